//--- source/ar_arbiter.sv
`timescale 1ns/1ps

module ar_arbiter import mem_bus_pkg::*; #(
    parameter int DATA_WIDTH = LINE_WIDTH
) (
    input  logic                  clk,
    input  logic                  reset_i,

    // Read clients
    rd_chan_if.arb                inst_chan,
    rd_chan_if.arb                data_chan,

    // AXI read address channel
    output logic [ID_WIDTH-1:0]   arid_o,
    output logic [ADDR_WIDTH-1:0] araddr_o,
    output logic [2:0]            arsize_o,
    output logic                  arvalid_o,
    input  logic                  arready_i,

    // AXI read data channel
    input  logic                  rvalid_i,
    input  logic [ID_WIDTH-1:0]   rid_i,
    input  logic [DATA_WIDTH-1:0] rdata_i
);

    logic                  slot_valid_q;
    logic                  owner_q;  // Set when the data port owns the slot
    logic [ADDR_WIDTH-1:0] addr_q;
    logic [2:0]            size_q;
    logic                  pick_data;
    logic                  load;
    logic                  ar_hs;

    // Data port has priority over instruction fetch
    assign pick_data = data_chan.req;
    assign load      = !slot_valid_q && (inst_chan.req || data_chan.req);
    assign ar_hs     = slot_valid_q && arready_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            slot_valid_q <= 1'b0;
        end else if (load) begin
            slot_valid_q <= 1'b1;
        end else if (ar_hs) begin
            slot_valid_q <= 1'b0;
        end
    end

    // Slot contents, only loaded while the slot is empty
    always_ff @(posedge clk) begin
        if (load) begin
            owner_q <= pick_data;
            addr_q  <= pick_data ? data_chan.addr : inst_chan.addr;
            size_q  <= pick_data ? data_chan.size : inst_chan.size;
        end
    end

    assign arvalid_o = slot_valid_q;
    assign arid_o    = owner_q ? DATA_ID : INST_ID;
    assign araddr_o  = addr_q;
    assign arsize_o  = size_q;

    // Grant pulse to the slot owner on the handshake
    assign inst_chan.granted = ar_hs && !owner_q;
    assign data_chan.granted = ar_hs && owner_q;

    // R beats are steered by ID, data is shared
    assign inst_chan.rvalid = rvalid_i && (rid_i == INST_ID);
    assign data_chan.rvalid = rvalid_i && (rid_i == DATA_ID);
    assign inst_chan.rdata  = rdata_i;
    assign data_chan.rdata  = rdata_i;

endmodule

//--- source/axi_mem_bridge.sv
`timescale 1ns/1ps

module axi_mem_bridge import mem_bus_pkg::*; #(
    parameter int DATA_WIDTH = LINE_WIDTH
) (
    input  logic                    clk,
    input  logic                    reset_i,

    // Instruction cache read
    input  logic                    icache_rd_req_i,
    input  logic [ADDR_WIDTH-1:0]   icache_rd_addr_i,
    input  access_type_e            icache_rd_type_i,
    output logic                    icache_rd_rdy_o,
    output logic                    icache_ret_valid_o,
    output logic [DATA_WIDTH-1:0]   icache_ret_data_o,

    // Data cache read
    input  logic                    dcache_rd_req_i,
    input  logic [ADDR_WIDTH-1:0]   dcache_rd_addr_i,
    input  access_type_e            dcache_rd_type_i,
    output logic                    dcache_rd_rdy_o,
    output logic                    dcache_ret_valid_o,
    output logic [DATA_WIDTH-1:0]   dcache_ret_data_o,

    // Data cache write
    input  logic                    dcache_wr_req_i,
    input  logic [ADDR_WIDTH-1:0]   dcache_wr_addr_i,
    input  access_type_e            dcache_wr_type_i,
    input  logic [DATA_WIDTH/8-1:0] dcache_wr_strb_i,
    input  logic [DATA_WIDTH-1:0]   dcache_wr_data_i,
    output logic                    dcache_wr_rdy_o,

    // AXI read address
    output logic [ID_WIDTH-1:0]     arid_o,
    output logic [ADDR_WIDTH-1:0]   araddr_o,
    output logic [7:0]              arlen_o,
    output logic [2:0]              arsize_o,
    output logic [1:0]              arburst_o,
    output logic [1:0]              arlock_o,
    output logic [3:0]              arcache_o,
    output logic [2:0]              arprot_o,
    output logic                    arvalid_o,
    input  logic                    arready_i,

    // AXI read data
    input  logic [ID_WIDTH-1:0]     rid_i,
    input  logic [DATA_WIDTH-1:0]   rdata_i,
    input  logic [1:0]              rresp_i,
    input  logic                    rlast_i,   // Single beat, always last
    input  logic                    rvalid_i,
    output logic                    rready_o,

    // AXI write address
    output logic [ID_WIDTH-1:0]     awid_o,
    output logic [ADDR_WIDTH-1:0]   awaddr_o,
    output logic [7:0]              awlen_o,
    output logic [2:0]              awsize_o,
    output logic [1:0]              awburst_o,
    output logic [1:0]              awlock_o,
    output logic [3:0]              awcache_o,
    output logic [2:0]              awprot_o,
    output logic                    awvalid_o,
    input  logic                    awready_i,

    // AXI write data
    output logic [ID_WIDTH-1:0]     wid_o,
    output logic [DATA_WIDTH-1:0]   wdata_o,
    output logic [DATA_WIDTH/8-1:0] wstrb_o,
    output logic                    wlast_o,
    output logic                    wvalid_o,
    input  logic                    wready_i,

    // AXI write response
    input  logic [ID_WIDTH-1:0]     bid_i,
    input  logic [1:0]              bresp_i,
    input  logic                    bvalid_i,
    output logic                    bready_o
);

    rd_chan_if #(.DATA_WIDTH(DATA_WIDTH)) inst_rd ();
    rd_chan_if #(.DATA_WIDTH(DATA_WIDTH)) data_rd ();

    rd_client_port #(.DATA_WIDTH(DATA_WIDTH)) u_inst_port (
        .clk         (clk),
        .reset_i     (reset_i),
        .rd_req_i    (icache_rd_req_i),
        .rd_addr_i   (icache_rd_addr_i),
        .rd_type_i   (icache_rd_type_i),
        .rd_rdy_o    (icache_rd_rdy_o),
        .ret_valid_o (icache_ret_valid_o),
        .ret_data_o  (icache_ret_data_o),
        .chan        (inst_rd)
    );

    rd_client_port #(.DATA_WIDTH(DATA_WIDTH)) u_data_port (
        .clk         (clk),
        .reset_i     (reset_i),
        .rd_req_i    (dcache_rd_req_i),
        .rd_addr_i   (dcache_rd_addr_i),
        .rd_type_i   (dcache_rd_type_i),
        .rd_rdy_o    (dcache_rd_rdy_o),
        .ret_valid_o (dcache_ret_valid_o),
        .ret_data_o  (dcache_ret_data_o),
        .chan        (data_rd)
    );

    ar_arbiter #(.DATA_WIDTH(DATA_WIDTH)) u_ar_arbiter (
        .clk       (clk),
        .reset_i   (reset_i),
        .inst_chan (inst_rd),
        .data_chan (data_rd),
        .arid_o    (arid_o),
        .araddr_o  (araddr_o),
        .arsize_o  (arsize_o),
        .arvalid_o (arvalid_o),
        .arready_i (arready_i),
        .rvalid_i  (rvalid_i),
        .rid_i     (rid_i),
        .rdata_i   (rdata_i)
    );

    write_port #(.DATA_WIDTH(DATA_WIDTH)) u_write_port (
        .clk       (clk),
        .reset_i   (reset_i),
        .wr_req_i  (dcache_wr_req_i),
        .wr_addr_i (dcache_wr_addr_i),
        .wr_type_i (dcache_wr_type_i),
        .wr_strb_i (dcache_wr_strb_i),
        .wr_data_i (dcache_wr_data_i),
        .wr_rdy_o  (dcache_wr_rdy_o),
        .awaddr_o  (awaddr_o),
        .awsize_o  (awsize_o),
        .awvalid_o (awvalid_o),
        .awready_i (awready_i),
        .wdata_o   (wdata_o),
        .wstrb_o   (wstrb_o),
        .wvalid_o  (wvalid_o),
        .wready_i  (wready_i),
        .bvalid_i  (bvalid_i)
    );

    // Single beat transfers only
    assign arlen_o   = 8'd0;
    assign arburst_o = BURST_INCR;
    assign arlock_o  = 2'b00;
    assign arcache_o = 4'b0000;
    assign arprot_o  = 3'b000;
    assign rready_o  = 1'b1;  // One outstanding read per ID, always room

    // Writes always come from the data cache
    assign awid_o    = DATA_ID;
    assign awlen_o   = 8'd0;
    assign awburst_o = BURST_INCR;
    assign awlock_o  = 2'b00;
    assign awcache_o = 4'b0000;
    assign awprot_o  = 3'b000;
    assign wid_o     = DATA_ID;
    assign wlast_o   = 1'b1;
    assign bready_o  = 1'b1;

endmodule

//--- source/mem_bus_pkg.sv
package mem_bus_pkg;

    // Bus geometry
    parameter int ADDR_WIDTH = 32;   // Byte address
    parameter int LINE_WIDTH = 128;  // One cache line, also one AXI beat
    parameter int ID_WIDTH   = 4;

    // Fixed transaction IDs, one per read client
    parameter logic [ID_WIDTH-1:0] INST_ID = 4'd0;  // Instruction line fetch
    parameter logic [ID_WIDTH-1:0] DATA_ID = 4'd1;  // Data reads and writes

    // AXI burst encoding for incrementing bursts
    parameter logic [1:0] BURST_INCR = 2'b01;

    // Cache side access width
    // Values follow the encoding the caches already drive
    typedef enum logic [2:0] {
        ACC_BYTE = 3'd0,
        ACC_HALF = 3'd1,
        ACC_WORD = 3'd2,
        ACC_LINE = 3'd4
    } access_type_e;

    // AXI size is log2 of the bytes per beat
    // A full 16-byte line maps to size 4
    function automatic logic [2:0] type_to_size(access_type_e acc_type);
        logic [2:0] size;
        case (acc_type)
            ACC_BYTE: size = 3'd0;
            ACC_HALF: size = 3'd1;
            ACC_WORD: size = 3'd2;
            ACC_LINE: size = 3'd4;
            default:  size = 3'd4;  // Unknown code, treat as a line
        endcase
        return size;
    endfunction

endpackage

//--- source/rd_chan_if.sv
`timescale 1ns/1ps

// Request and return path between one read client and the AR/R arbiter
interface rd_chan_if import mem_bus_pkg::*; #(
    parameter int DATA_WIDTH = LINE_WIDTH
) ();

    logic                  req;      // Held until granted
    logic [ADDR_WIDTH-1:0] addr;
    logic [2:0]            size;     // AXI size code
    logic                  granted;  // One cycle, AR handshake done
    logic                  rvalid;   // One cycle, R beat for this client
    logic [DATA_WIDTH-1:0] rdata;

    modport client (
        output req,
        output addr,
        output size,
        input  granted,
        input  rvalid,
        input  rdata
    );

    modport arb (
        input  req,
        input  addr,
        input  size,
        output granted,
        output rvalid,
        output rdata
    );

endinterface

//--- source/rd_client_port.sv
`timescale 1ns/1ps

module rd_client_port import mem_bus_pkg::*; #(
    parameter int DATA_WIDTH = LINE_WIDTH
) (
    input  logic                  clk,
    input  logic                  reset_i,

    // Cache side
    input  logic                  rd_req_i,
    input  logic [ADDR_WIDTH-1:0] rd_addr_i,
    input  access_type_e          rd_type_i,
    output logic                  rd_rdy_o,
    output logic                  ret_valid_o,
    output logic [DATA_WIDTH-1:0] ret_data_o,

    // Arbiter side
    rd_chan_if.client             chan
);

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_REQ  = 2'd1;  // Waiting for the AR slot
    localparam logic [1:0] ST_WAIT = 2'd2;  // AR sent, waiting for R

    logic [1:0]            state_q;
    logic [ADDR_WIDTH-1:0] addr_q;
    logic [2:0]            size_q;
    logic                  accept;

    assign rd_rdy_o = (state_q == ST_IDLE);
    assign accept   = rd_rdy_o && rd_req_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= ST_IDLE;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (rd_req_i) begin
                        state_q <= ST_REQ;
                    end
                end
                ST_REQ: begin
                    if (chan.granted) begin
                        state_q <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    if (chan.rvalid) begin
                        state_q <= ST_IDLE;  // Ready again next cycle
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // Request payload, captured once at acceptance
    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q <= rd_addr_i;
            size_q <= type_to_size(rd_type_i);
        end
    end

    assign chan.req  = (state_q == ST_REQ);
    assign chan.addr = addr_q;
    assign chan.size = size_q;

    // Return goes straight through in the R beat cycle
    assign ret_valid_o = (state_q == ST_WAIT) && chan.rvalid;
    assign ret_data_o  = chan.rdata;

endmodule

//--- source/write_port.sv
`timescale 1ns/1ps

module write_port import mem_bus_pkg::*; #(
    parameter int DATA_WIDTH = LINE_WIDTH
) (
    input  logic                    clk,
    input  logic                    reset_i,

    // Data cache write side
    input  logic                    wr_req_i,
    input  logic [ADDR_WIDTH-1:0]   wr_addr_i,
    input  access_type_e            wr_type_i,
    input  logic [DATA_WIDTH/8-1:0] wr_strb_i,
    input  logic [DATA_WIDTH-1:0]   wr_data_i,
    output logic                    wr_rdy_o,

    // AXI write address and data
    output logic [ADDR_WIDTH-1:0]   awaddr_o,
    output logic [2:0]              awsize_o,
    output logic                    awvalid_o,
    input  logic                    awready_i,
    output logic [DATA_WIDTH-1:0]   wdata_o,
    output logic [DATA_WIDTH/8-1:0] wstrb_o,
    output logic                    wvalid_o,
    input  logic                    wready_i,

    // AXI write response
    input  logic                    bvalid_i
);

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_SEND = 2'd1;  // AW and W in flight
    localparam logic [1:0] ST_RESP = 2'd2;  // Both sent, waiting for B

    logic [1:0] state_q;
    logic       aw_done_q;
    logic       w_done_q;
    logic       accept;
    logic       aw_hs;
    logic       w_hs;
    logic       aw_sent;
    logic       w_sent;

    assign wr_rdy_o = (state_q == ST_IDLE);
    assign accept   = wr_rdy_o && wr_req_i;

    assign awvalid_o = (state_q == ST_SEND) && !aw_done_q;
    assign wvalid_o  = (state_q == ST_SEND) && !w_done_q;
    assign aw_hs     = awvalid_o && awready_i;
    assign w_hs      = wvalid_o && wready_i;

    // Sent now or in an earlier cycle
    assign aw_sent = aw_done_q || aw_hs;
    assign w_sent  = w_done_q || w_hs;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q   <= ST_IDLE;
            aw_done_q <= 1'b0;
            w_done_q  <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (wr_req_i) begin
                        state_q   <= ST_SEND;
                        aw_done_q <= 1'b0;
                        w_done_q  <= 1'b0;
                    end
                end
                ST_SEND: begin
                    aw_done_q <= aw_sent;  // Each channel drops on its own
                    w_done_q  <= w_sent;
                    if (aw_sent && w_sent) begin
                        state_q <= ST_RESP;
                    end
                end
                ST_RESP: begin
                    if (bvalid_i) begin
                        state_q <= ST_IDLE;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // Write payload held stable until both handshakes
    always_ff @(posedge clk) begin
        if (accept) begin
            awaddr_o <= wr_addr_i;
            awsize_o <= type_to_size(wr_type_i);
            wdata_o  <= wr_data_i;
            wstrb_o  <= wr_strb_i;
        end
    end

endmodule

//--- tb.f
source/mem_bus_pkg.sv
source/rd_chan_if.sv
source/rd_client_port.sv
source/ar_arbiter.sv
source/write_port.sv
source/axi_mem_bridge.sv
testbench/axi_slave_model.sv
testbench/tb_axi_mem_bridge.sv

//--- testbench/axi_slave_model.sv
`timescale 1ns/1ps

// Single beat AXI3 slave, rready and bready assumed high
module axi_slave_model import mem_bus_pkg::*; (
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic [ID_WIDTH-1:0]     arid_i,
    input  logic [ADDR_WIDTH-1:0]   araddr_i,
    input  logic                    arvalid_i,
    output logic                    arready_o,
    output logic [ID_WIDTH-1:0]     rid_o,
    output logic [LINE_WIDTH-1:0]   rdata_o,
    output logic                    rvalid_o,
    input  logic [ADDR_WIDTH-1:0]   awaddr_i,
    input  logic                    awvalid_i,
    output logic                    awready_o,
    input  logic [LINE_WIDTH-1:0]   wdata_i,
    input  logic [LINE_WIDTH/8-1:0] wstrb_i,
    input  logic                    wvalid_i,
    output logic                    wready_o,
    output logic                    bvalid_o
);

    localparam logic [LINE_WIDTH-1:0] FILL_KEY = 128'h3c5a_96e1_0f87_d2b4_a55a_7e18_c3d1_692f;

    integer                seed = 32'h031576bd;
    logic [LINE_WIDTH-1:0] mem [logic [ADDR_WIDTH-5:0]];  // Sparse, one entry per line
    logic [2:0]            ar_cnt, r_cnt, aw_cnt, w_cnt, b_cnt;
    logic                  pend_q [2];  // Outstanding read per ID
    logic [ADDR_WIDTH-1:0] pend_addr [2];
    logic                  aw_got, w_got, pick;
    logic [ADDR_WIDTH-1:0] aw_addr;
    logic [LINE_WIDTH-1:0] w_data, line;
    logic [LINE_WIDTH/8-1:0] w_strb;

    function automatic logic [2:0] delay();
        return 3'($unsigned($random(seed)) % 6);
    endfunction

    function automatic logic [LINE_WIDTH-1:0] line_of(logic [ADDR_WIDTH-1:0] addr);
        if (mem.exists(addr[ADDR_WIDTH-1:4]))
            return mem[addr[ADDR_WIDTH-1:4]];
        return {4{addr[ADDR_WIDTH-1:4], 4'h0}} ^ FILL_KEY;
    endfunction

    always @(posedge clk) begin
        if (reset_i) begin
            {arready_o, awready_o, wready_o, rvalid_o, bvalid_o} <= '0;
            {ar_cnt, r_cnt, aw_cnt, w_cnt, b_cnt} <= '0;
            pend_q[0] <= 1'b0;
            pend_q[1] <= 1'b0;
            aw_got    <= 1'b0;
            w_got     <= 1'b0;
        end else begin
            if (arvalid_i && arready_o) begin
                pend_q[arid_i[0]]    <= 1'b1;
                pend_addr[arid_i[0]] <= araddr_i;
                arready_o            <= 1'b0;
                ar_cnt               <= delay();
            end else if (!arready_o) begin
                if (ar_cnt == 0) arready_o <= 1'b1;
                else ar_cnt <= ar_cnt - 1;
            end
            // Either pending ID may go first
            if (rvalid_o) begin
                rvalid_o <= 1'b0;
                r_cnt    <= delay();
            end else if (pend_q[0] || pend_q[1]) begin
                if (r_cnt != 0) begin
                    r_cnt <= r_cnt - 1;
                end else begin
                    pick          = pend_q[1] && (!pend_q[0] || ($random(seed) % 2 != 0));
                    rvalid_o     <= 1'b1;
                    rid_o        <= ID_WIDTH'(pick);  // Echo of the arid
                    rdata_o      <= line_of(pend_addr[pick]);
                    pend_q[pick] <= 1'b0;
                end
            end
            if (awvalid_i && awready_o) begin
                aw_got    <= 1'b1;
                aw_addr   <= awaddr_i;
                awready_o <= 1'b0;
                aw_cnt    <= delay();
            end else if (!awready_o) begin
                if (aw_cnt == 0) awready_o <= 1'b1;
                else aw_cnt <= aw_cnt - 1;
            end
            if (wvalid_i && wready_o) begin
                w_got    <= 1'b1;
                w_data   <= wdata_i;
                w_strb   <= wstrb_i;
                wready_o <= 1'b0;
                w_cnt    <= delay();
            end else if (!wready_o) begin
                if (w_cnt == 0) wready_o <= 1'b1;
                else w_cnt <= w_cnt - 1;
            end
            if (bvalid_o) begin
                bvalid_o <= 1'b0;
                b_cnt    <= delay();
            end else if (aw_got && w_got) begin
                if (b_cnt != 0) begin
                    b_cnt <= b_cnt - 1;
                end else begin
                    line = line_of(aw_addr);
                    for (int i = 0; i < LINE_WIDTH / 8; i++)
                        if (w_strb[i]) line[8*i +: 8] = w_data[8*i +: 8];
                    mem[aw_addr[ADDR_WIDTH-1:4]] = line;
                    bvalid_o <= 1'b1;
                    aw_got   <= 1'b0;
                    w_got    <= 1'b0;
                end
            end
        end
    end

endmodule

//--- testbench/tb_axi_mem_bridge.sv
`timescale 1ns/1ps

module tb_axi_mem_bridge import mem_bus_pkg::*; ();

    localparam int PERIOD = 40;
    localparam int RESET_CYCLES = 16;
    localparam int N = 13;
    localparam logic [LINE_WIDTH-1:0] FILL_KEY = 128'h3c5a_96e1_0f87_d2b4_a55a_7e18_c3d1_692f;

    typedef enum logic [1:0] {OP_IRD, OP_DRD, OP_WR, OP_PAIR} op_e;
    typedef struct {
        op_e                   op;
        logic [ADDR_WIDTH-1:0] addr;
        logic [ADDR_WIDTH-1:0] addr2;  // Data address of a paired read
        access_type_e          acc;
        logic [15:0]           strb;
        logic [LINE_WIDTH-1:0] data;
        logic [2:0]            exp_size;
    } stim_t;

    logic clk = 1'b0;
    logic reset_i;
    logic icache_rd_req_i, dcache_rd_req_i, dcache_wr_req_i;
    logic [ADDR_WIDTH-1:0] icache_rd_addr_i, dcache_rd_addr_i, dcache_wr_addr_i;
    logic [ADDR_WIDTH-1:0] araddr_o, awaddr_o, aw_addr_q;
    access_type_e icache_rd_type_i, dcache_rd_type_i, dcache_wr_type_i;
    logic [15:0] dcache_wr_strb_i, wstrb_o, w_strb_q;
    logic [LINE_WIDTH-1:0] dcache_wr_data_i, icache_ret_data_o, dcache_ret_data_o;
    logic [LINE_WIDTH-1:0] rdata_i, wdata_o;
    logic [LINE_WIDTH-1:0] i_data, d_data, w_data_q;
    logic icache_rd_rdy_o, icache_ret_valid_o, dcache_rd_rdy_o;
    logic dcache_ret_valid_o, dcache_wr_rdy_o;
    logic [ID_WIDTH-1:0] arid_o, rid_i, awid_o, wid_o, bid_i;
    logic [7:0] arlen_o, awlen_o;
    logic [2:0] arsize_o, arprot_o, awsize_o, awprot_o, aw_size_q;
    logic [1:0] arburst_o, arlock_o, awburst_o, awlock_o, rresp_i, bresp_i;
    logic [3:0] arcache_o, awcache_o;
    logic arvalid_o, arready_i, rlast_i, rvalid_i, rready_o;
    logic awvalid_o, awready_i, wlast_o, wvalid_o, wready_i, bvalid_i, bready_o;
    logic [ID_WIDTH-1:0] ar_ids [$];
    logic [ADDR_WIDTH-1:0] ar_addrs [$];
    logic [2:0] ar_sizes [$];
    logic [7:0] ar_lens [$];
    logic [LINE_WIDTH-1:0] ref_mem [logic [ADDR_WIDTH-5:0]];
    int i_rets = 0, d_rets = 0, b_done = 0, errors = 0;
    stim_t stim [N];

    assign rresp_i = 2'b00;
    assign rlast_i = 1'b1;
    assign bresp_i = 2'b00;
    assign bid_i   = DATA_ID;

    always #(PERIOD / 2) clk = ~clk;

    axi_mem_bridge axi_mem_bridge_i (.*);

    axi_slave_model slave (
        .clk(clk), .reset_i(reset_i),
        .arid_i(arid_o), .araddr_i(araddr_o), .arvalid_i(arvalid_o), .arready_o(arready_i),
        .rid_o(rid_i), .rdata_o(rdata_i), .rvalid_o(rvalid_i),
        .awaddr_i(awaddr_o), .awvalid_i(awvalid_o), .awready_o(awready_i),
        .wdata_i(wdata_o), .wstrb_i(wstrb_o), .wvalid_i(wvalid_o), .wready_o(wready_i),
        .bvalid_o(bvalid_i)
    );

    function automatic logic [LINE_WIDTH-1:0] ref_line(logic [ADDR_WIDTH-1:0] addr);
        if (ref_mem.exists(addr[ADDR_WIDTH-1:4]))
            return ref_mem[addr[ADDR_WIDTH-1:4]];
        return {4{addr[ADDR_WIDTH-1:4], 4'h0}} ^ FILL_KEY;
    endfunction

    task automatic check(input string name, input logic [LINE_WIDTH-1:0] exp,
                         input logic [LINE_WIDTH-1:0] act);
        if (exp !== act) begin
            $display("[FAIL] %0t %s expected %h got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    // Finds the captured AR beat of one ID and checks its fields
    task automatic check_ar(input logic [ID_WIDTH-1:0] id, input logic [ADDR_WIDTH-1:0] exp_addr,
                            input logic [2:0] exp_size);
        foreach (ar_ids[k]) begin
            if (ar_ids[k] == id) begin
                check("araddr_o", exp_addr, ar_addrs[k]);
                check("arsize_o", exp_size, ar_sizes[k]);
                check("arlen_o", 0, ar_lens[k]);
                ar_ids.delete(k);
                ar_addrs.delete(k);
                ar_sizes.delete(k);
                ar_lens.delete(k);
                return;
            end
        end
        $display("No AR handshake was seen for ID %0d", id);
        errors++;
    endtask

    // Bus monitor, all counts move on the clock edge
    always @(posedge clk) begin
        if (arvalid_o && arready_i) begin
            ar_ids.push_back(arid_o);
            ar_addrs.push_back(araddr_o);
            ar_sizes.push_back(arsize_o);
            ar_lens.push_back(arlen_o);
            check("arburst_o", 2'b01, arburst_o);  // INCR
            check("arlock_o", 0, arlock_o);
            check("arcache_o", 0, arcache_o);
            check("arprot_o", 0, arprot_o);
        end
        if (rvalid_i) check("rready_o", 1, rready_o);
        if (icache_ret_valid_o) begin
            i_rets <= i_rets + 1;
            i_data <= icache_ret_data_o;
        end
        if (dcache_ret_valid_o) begin
            d_rets <= d_rets + 1;
            d_data <= dcache_ret_data_o;
        end
        if (awvalid_o && awready_i) begin
            aw_addr_q <= awaddr_o;
            aw_size_q <= awsize_o;
            check("awid_o", DATA_ID, awid_o);
            check("awlen_o", 0, awlen_o);
            check("awburst_o", 2'b01, awburst_o);
            check("awlock_o", 0, awlock_o);
            check("awcache_o", 0, awcache_o);
            check("awprot_o", 0, awprot_o);
        end
        if (wvalid_o && wready_i) begin
            w_data_q <= wdata_o;
            w_strb_q <= wstrb_o;
            check("wid_o", DATA_ID, wid_o);
            check("wlast_o", 1, wlast_o);
        end
        if (bvalid_i) check("bready_o", 1, bready_o);
        if (bvalid_i && bready_o) b_done <= b_done + 1;
    end

    initial begin
        #(RESET_CYCLES * PERIOD + N * 40 * PERIOD);
        $display("Watchdog timeout, a request never completed");
        $display("Testbench failed");
        $finish;
    end

    initial begin
        stim_t s;
        logic [ADDR_WIDTH-1:0] daddr;
        logic [LINE_WIDTH-1:0] line;
        int i_exp;
        int d_exp;
        int b_exp;
        i_exp = 0;
        d_exp = 0;
        b_exp = 0;
        stim[0]  = '{OP_IRD,  32'h1000, 0, ACC_LINE, 16'h0, 0, 3'd4};
        stim[1]  = '{OP_DRD,  32'h2004, 0, ACC_BYTE, 16'h0, 0, 3'd0};
        stim[2]  = '{OP_DRD,  32'h2008, 0, ACC_HALF, 16'h0, 0, 3'd1};
        stim[3]  = '{OP_DRD,  32'h200c, 0, ACC_WORD, 16'h0, 0, 3'd2};
        stim[4]  = '{OP_DRD,  32'h2010, 0, ACC_LINE, 16'h0, 0, 3'd4};
        stim[5]  = '{OP_WR,   32'h2004, 0, ACC_WORD, 16'h00f0, {4{32'hdeadbeef}}, 3'd2};
        stim[6]  = '{OP_DRD,  32'h2000, 0, ACC_LINE, 16'h0, 0, 3'd4};
        stim[7]  = '{OP_WR,   32'h3000, 0, ACC_BYTE, 16'h0001, {16{8'h77}}, 3'd0};
        stim[8]  = '{OP_WR,   32'h3000, 0, ACC_LINE, 16'hff00, {8{16'h1234}}, 3'd4};
        stim[9]  = '{OP_DRD,  32'h3002, 0, ACC_HALF, 16'h0, 0, 3'd1};
        stim[10] = '{OP_PAIR, 32'h1010, 32'h3000, ACC_LINE, 16'h0, 0, 3'd4};
        stim[11] = '{OP_PAIR, 32'h4000, 32'h2004, ACC_WORD, 16'h0, 0, 3'd2};
        stim[12] = '{OP_IRD,  32'h2000, 0, ACC_LINE, 16'h0, 0, 3'd4};
        reset_i = 1'b1;
        {icache_rd_req_i, dcache_rd_req_i, dcache_wr_req_i} = '0;
        {icache_rd_addr_i, dcache_rd_addr_i, dcache_wr_addr_i} = '0;
        icache_rd_type_i = ACC_LINE;
        dcache_rd_type_i = ACC_LINE;
        dcache_wr_type_i = ACC_LINE;
        dcache_wr_strb_i = '0;
        dcache_wr_data_i = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset_i <= 1'b0;
        @(posedge clk);
        check("ready and valid outputs after reset", 8'b1110_0000,
              {icache_rd_rdy_o, dcache_rd_rdy_o, dcache_wr_rdy_o, arvalid_o, awvalid_o,
               wvalid_o, icache_ret_valid_o, dcache_ret_valid_o});
        for (int n = 0; n < N; n++) begin
            s = stim[n];
            daddr = (s.op == OP_PAIR) ? s.addr2 : s.addr;
            @(posedge clk);
            while (!(icache_rd_rdy_o && dcache_rd_rdy_o && dcache_wr_rdy_o)) @(posedge clk);
            if (s.op == OP_IRD || s.op == OP_PAIR) begin
                icache_rd_req_i  <= 1'b1;
                icache_rd_addr_i <= s.addr;
                icache_rd_type_i <= ACC_LINE;
                i_exp++;
            end
            if (s.op == OP_DRD || s.op == OP_PAIR) begin
                dcache_rd_req_i  <= 1'b1;
                dcache_rd_addr_i <= daddr;
                dcache_rd_type_i <= s.acc;
                d_exp++;
            end
            if (s.op == OP_WR) begin
                dcache_wr_req_i  <= 1'b1;
                dcache_wr_addr_i <= s.addr;
                dcache_wr_type_i <= s.acc;
                dcache_wr_strb_i <= s.strb;
                dcache_wr_data_i <= s.data;
                line = ref_line(s.addr);
                for (int b = 0; b < 16; b++)
                    if (s.strb[b]) line[8*b +: 8] = s.data[8*b +: 8];
                ref_mem[s.addr[ADDR_WIDTH-1:4]] = line;
                b_exp++;
            end
            @(posedge clk);
            icache_rd_req_i <= 1'b0;
            dcache_rd_req_i <= 1'b0;
            dcache_wr_req_i <= 1'b0;
            while (i_rets < i_exp || d_rets < d_exp || b_done < b_exp) @(posedge clk);
            if (s.op == OP_IRD || s.op == OP_PAIR) begin
                check("icache_ret_data_o", ref_line(s.addr), i_data);
                check_ar(INST_ID, s.addr, 3'd4);
            end
            if (s.op == OP_DRD || s.op == OP_PAIR) begin
                check("dcache_ret_data_o", ref_line(daddr), d_data);
                check_ar(DATA_ID, daddr, s.exp_size);
            end
            if (s.op == OP_WR) begin
                check("awaddr_o", s.addr, aw_addr_q);
                check("awsize_o", s.exp_size, aw_size_q);
                check("wstrb_o", s.strb, w_strb_q);
                check("wdata_o", s.data, w_data_q);
            end
        end
        repeat (20) @(posedge clk);  // Late duplicates would show up here
        check("icache_ret_valid_o count", i_exp, i_rets);
        check("dcache_ret_valid_o count", d_exp, d_rets);
        check("write response count", b_exp, b_done);
        check("unmatched AR handshakes", 0, ar_ids.size());
        $display("Errors: %0d, icache returns %0d, dcache returns %0d, writes %0d",
                 errors, i_rets, d_rets, b_done);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule
